//--- redmule_cfg_pkg.sv
package redmule_cfg_pkg;

  // Systolic array geometry
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ARRAY_WIDTH  = 12;
  localparam int unsigned PIPE_REGS    = 3;

  // Depth of one tile, a full sweep through every pipeline stage of a row
  localparam int unsigned TOT_DEPTH = ARRAY_HEIGHT * (PIPE_REGS + 1);

  localparam int unsigned ITER_W = 16;
  localparam int unsigned DIM_W  = 8;
  localparam int unsigned REG_W  = 32;

  // Widths of the small sequencing counters
  localparam int unsigned SHIFT_W = $clog2(ARRAY_HEIGHT);
  localparam int unsigned WAIT_W  = $clog2(PIPE_REGS + 1);
  localparam int unsigned DEPTH_W = $clog2(TOT_DEPTH);

  // Scheduler FSM state encoding
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_PRELOAD = 2'd1;
  localparam logic [1:0] ST_LOAD_W  = 2'd2;
  localparam logic [1:0] ST_WAIT    = 2'd3;

endpackage

//--- redmule_reg_pkg.sv
package redmule_reg_pkg;

  // Iteration words hold the column count in the low half and the row count in the high half
  localparam int unsigned ITER_COLS_LO = 0;
  localparam int unsigned ITER_COLS_HI = 15;
  localparam int unsigned ITER_ROWS_LO = 16;
  localparam int unsigned ITER_ROWS_HI = 31;

  // Leftover word, one byte per edge tile dimension
  // A zero byte means the edge tile is a full tile
  localparam int unsigned LO_W_WIDTH_LO  = 0;
  localparam int unsigned LO_W_WIDTH_HI  = 7;
  localparam int unsigned LO_W_HEIGHT_LO = 8;
  localparam int unsigned LO_W_HEIGHT_HI = 15;
  localparam int unsigned LO_X_HEIGHT_LO = 16;
  localparam int unsigned LO_X_HEIGHT_HI = 23;
  localparam int unsigned LO_X_WIDTH_LO  = 24;
  localparam int unsigned LO_X_WIDTH_HI  = 31;

endpackage

//--- redmule_sched_fsm.sv
`timescale 1ns/100ps

module redmule_sched_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic first_load_i,
  input  logic y_required_i,
  input  logic x_full_i,
  input  logic y_loaded_i,
  input  logic w_valid_i,
  input  logic x_check_en_i,
  input  logic result_due_i,
  input  logic w_done_i,
  output logic load_w_o,
  output logic shift_w_o,
  output logic stall_o,
  output logic start_o,
  output logic start_comp_o,
  output logic preload_exit_o,
  output logic computing_o,
  output logic w_loaded_o
);
  import redmule_cfg_pkg::*;

  logic [1:0]        state_q, state_d;
  logic [WAIT_W-1:0] wait_cnt_q;
  logic              first_load_q;
  logic              computing_q;
  logic              stall;

  // The array only stalls while a weight row is being loaded
  // Each term is a resource that the next LOAD_W step depends on
  assign stall = (state_q == ST_LOAD_W) &&
                 ((!w_valid_i && !w_done_i) ||
                  (!x_full_i && x_check_en_i) ||
                  (!y_loaded_i && result_due_i && !w_done_i));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (first_load_i) begin
          state_d = ST_PRELOAD;
        end
      end
      // Hold until the X buffer, and Y when it takes part, hold their first tile
      ST_PRELOAD: begin
        if (x_full_i && (y_loaded_i || !y_required_i)) begin
          state_d = ST_LOAD_W;
        end
      end
      ST_LOAD_W: begin
        if (!stall) begin
          state_d = ST_WAIT;
        end
      end
      default: begin
        if (wait_cnt_q == WAIT_W'(PIPE_REGS)) begin
          state_d = ST_LOAD_W;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else if (clear_i) begin
      state_q      <= ST_IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // WAIT covers PIPE_REGS+1 cycles so results drain through the cell pipeline
      if (state_q == ST_WAIT) begin
        wait_cnt_q <= (wait_cnt_q == WAIT_W'(PIPE_REGS)) ? '0 : wait_cnt_q + 1'b1;
      end
      if (load_w_o) begin
        first_load_q <= 1'b0;
      end
      if (preload_exit_o) begin
        computing_q <= 1'b1;
      end
    end
  end

  assign load_w_o       = (state_q == ST_LOAD_W) && !stall;
  assign shift_w_o      = ((state_q == ST_LOAD_W) || (state_q == ST_WAIT)) && !stall;
  assign stall_o        = stall;
  assign start_o        = (state_q == ST_IDLE) && first_load_i;
  assign preload_exit_o = (state_q == ST_PRELOAD) && (state_d == ST_LOAD_W);
  assign start_comp_o   = first_load_q && (state_d == ST_LOAD_W) && !stall;
  assign computing_o    = computing_q;
  assign w_loaded_o     = load_w_o;

endmodule

//--- redmule_x_tile_ctrl.sv
`timescale 1ns/100ps

module redmule_x_tile_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] x_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] w_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] leftovers_i,
  input  logic                              x_full_i,
  input  logic                              x_empty_i,
  input  logic                              x_valid_i,
  input  logic                              load_w_i,
  input  logic                              start_i,
  input  logic                              preload_exit_i,
  output logic                              x_load_o,
  output logic                              x_h_shift_o,
  output logic                              x_pad_setup_o,
  output logic                              x_rst_w_index_o,
  output logic                              last_x_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] x_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] x_width_o,
  output logic                              x_check_en_o
);
  import redmule_cfg_pkg::*;
  import redmule_reg_pkg::*;

  logic [ITER_W-1:0]  x_cols_last, x_rows_last, w_cols_last;
  logic [ITER_W-1:0]  cols_q, sweep_q, rows_q;
  logic [SHIFT_W-1:0] shift_q;
  logic [DIM_W-1:0]   lo_x_height, lo_x_width;
  logic               done_q, reload_q, empty_q, refill_q;
  logic               cols_wrap, sweep_wrap, done_en, shift_last;
  logic               reload_en, reload_rst;

  assign x_cols_last = x_iters_i[ITER_COLS_HI:ITER_COLS_LO] - ITER_W'(1);
  assign x_rows_last = x_iters_i[ITER_ROWS_HI:ITER_ROWS_LO] - ITER_W'(1);
  assign w_cols_last = w_iters_i[ITER_COLS_HI:ITER_COLS_LO] - ITER_W'(1);
  assign lo_x_height = leftovers_i[LO_X_HEIGHT_HI:LO_X_HEIGHT_LO];
  assign lo_x_width  = leftovers_i[LO_X_WIDTH_HI:LO_X_WIDTH_LO];

  // Each consumed X tile advances the column index; a full column pass is one W sweep
  assign cols_wrap  = x_empty_i && (cols_q == x_cols_last);
  assign sweep_wrap = cols_wrap && (sweep_q == w_cols_last);
  assign done_en    = sweep_wrap && (rows_q == x_rows_last) && !done_q;
  assign shift_last = shift_q == SHIFT_W'(ARRAY_HEIGHT - 1);

  // A reload is requested on start, after each drained tile, or when a full buffer empties
  assign reload_en  = start_i || x_empty_i || (empty_q && !x_full_i);
  assign reload_rst = x_full_i && !reload_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {cols_q, sweep_q, rows_q, shift_q} <= '0;
      {done_q, reload_q, empty_q, refill_q} <= '0;
    end else if (clear_i) begin
      {cols_q, sweep_q, rows_q, shift_q} <= '0;
      {done_q, reload_q, empty_q, refill_q} <= '0;
    end else begin
      if (x_empty_i && !done_q) begin
        cols_q <= cols_wrap ? '0 : cols_q + 1'b1;
        if (cols_wrap) begin
          sweep_q <= sweep_wrap ? '0 : sweep_q + 1'b1;
        end
        if (sweep_wrap) begin
          rows_q <= rows_q + 1'b1;
        end
      end
      if (done_en) begin
        done_q <= 1'b1;
      end
      if (load_w_i) begin
        shift_q <= shift_last ? '0 : shift_q + 1'b1;
      end
      if (reload_rst) begin
        reload_q <= 1'b0;
      end else if (reload_en) begin
        reload_q <= 1'b1;
      end
      if (!x_full_i) begin
        empty_q <= 1'b0;
      end else if (x_empty_i) begin
        empty_q <= 1'b1;
      end
      // A refilled buffer must be full before the shift wraps into it
      if (x_rst_w_index_o) begin
        refill_q <= 1'b0;
      end else if (x_empty_i) begin
        refill_q <= 1'b1;
      end
    end
  end

  assign x_load_o        = reload_q && !reload_rst && x_valid_i;
  assign x_h_shift_o     = load_w_i;
  assign x_pad_setup_o   = preload_exit_i;
  assign x_rst_w_index_o = load_w_i && shift_last && x_full_i;
  assign last_x_o        = done_en;
  assign x_check_en_o    = refill_q && shift_last && !done_q;

  assign x_height_o = ((cols_q == x_cols_last) && (lo_x_height != '0)) ?
                      lo_x_height : DIM_W'(TOT_DEPTH);
  assign x_width_o  = ((rows_q == x_rows_last) && (lo_x_width != '0)) ?
                      lo_x_width : DIM_W'(ARRAY_WIDTH);

endmodule

//--- redmule_w_tile_ctrl.sv
`timescale 1ns/100ps

module redmule_w_tile_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] w_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] x_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] leftovers_i,
  input  logic                              load_w_i,
  input  logic                              shift_w_i,
  input  logic                              w_valid_i,
  output logic                              w_load_o,
  output logic                              w_shift_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] w_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] w_width_o,
  output logic                              w_done_o,
  output logic                              w_col_wrap_o
);
  import redmule_cfg_pkg::*;
  import redmule_reg_pkg::*;

  logic [ITER_W-1:0] w_rows, w_rows_last, w_cols_last, x_rows_last;
  logic [ITER_W-1:0] rows_q, cols_q, mat_q;
  logic [DIM_W-1:0]  lo_w_height, lo_w_width;
  logic              done_q, rows_en, mat_en, done_en;

  assign w_rows      = w_iters_i[ITER_ROWS_HI:ITER_ROWS_LO];
  assign w_rows_last = w_rows - ITER_W'(1);
  assign w_cols_last = w_iters_i[ITER_COLS_HI:ITER_COLS_LO] - ITER_W'(1);
  assign x_rows_last = x_iters_i[ITER_ROWS_HI:ITER_ROWS_LO] - ITER_W'(1);
  assign lo_w_height = leftovers_i[LO_W_HEIGHT_HI:LO_W_HEIGHT_LO];
  assign lo_w_width  = leftovers_i[LO_W_WIDTH_HI:LO_W_WIDTH_LO]; 

  // One W row is consumed per unstalled LOAD_W cycle with valid data
  assign rows_en      = load_w_i && w_valid_i && !done_q;
  assign w_col_wrap_o = rows_en && (rows_q == w_rows_last);
  assign mat_en       = w_col_wrap_o && (cols_q == w_cols_last);
  // The whole W matrix is swept once per X row tile
  assign done_en      = mat_en && (mat_q == x_rows_last);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {rows_q, cols_q, mat_q} <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      {rows_q, cols_q, mat_q} <= '0;
      done_q <= 1'b0;
    end else begin
      if (rows_en) begin
        rows_q <= w_col_wrap_o ? '0 : rows_q + 1'b1;
      end
      if (w_col_wrap_o) begin
        cols_q <= mat_en ? '0 : cols_q + 1'b1;
      end
      if (mat_en) begin
        mat_q <= mat_q + 1'b1;
      end
      if (done_en) begin
        done_q <= 1'b1;
      end
    end
  end

  assign w_load_o  = load_w_i;
  assign w_shift_o = shift_w_i;
  assign w_done_o  = done_q;

  // The short edge rows cover the last PIPE_REGS+1 row steps of a sweep
  assign w_height_o = ((rows_q >= w_rows - ITER_W'(PIPE_REGS + 1)) && (lo_w_height != '0)) ?
                      lo_w_height : DIM_W'(ARRAY_HEIGHT);
  assign w_width_o  = ((cols_q == w_cols_last) && (lo_w_width != '0)) ?
                      lo_w_width : DIM_W'(TOT_DEPTH);

endmodule

//--- redmule_z_tile_ctrl.sv
`timescale 1ns/100ps

module redmule_z_tile_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] w_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0] leftovers_i,
  input  logic                              z_empty_i,
  input  logic                              y_valid_i,
  input  logic                              z_ready_i,
  input  logic                              w_col_wrap_i,
  input  logic                              stall_i,
  input  logic                              start_comp_i,
  input  logic                              reg_enable_i,
  output logic                              y_push_enable_o,
  output logic                              z_fill_o,
  output logic                              z_first_load_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] y_width_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] y_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] z_width_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0] z_height_o,
  output logic                              y_valid_o,
  output logic                              z_ready_o,
  output logic                              result_due_o
);
  import redmule_cfg_pkg::*;
  import redmule_reg_pkg::*;

  logic [ITER_W-1:0]  w_cols_last, w_rows_last, y_cols_q, y_rows_q;
  logic [WAIT_W-1:0]  wait_q;
  logic [DEPTH_W-1:0] avail_q, push_q;
  logic [DIM_W-1:0]   lo_w_height, lo_w_width, y_width, y_height;
  logic [DIM_W-1:0]   z_width_q, z_height_q, y_height_last, z_height_last;
  logic               wait_en_q, avail_en_q, push_en_q;
  logic               y_cols_wrap, wait_last, wait_clr, avail_clr, push_set, push_clr;

  assign w_cols_last = w_iters_i[ITER_COLS_HI:ITER_COLS_LO] - ITER_W'(1);
  assign w_rows_last = w_iters_i[ITER_ROWS_HI:ITER_ROWS_LO] - ITER_W'(1);
  assign lo_w_height = leftovers_i[LO_W_HEIGHT_HI:LO_W_HEIGHT_LO];
  assign lo_w_width  = leftovers_i[LO_W_WIDTH_HI:LO_W_WIDTH_LO];

  assign y_cols_wrap   = z_empty_i && (y_cols_q == w_cols_last);
  assign y_height_last = y_height - DIM_W'(1);
  assign z_height_last = z_height_q - DIM_W'(1);

  // After a W row sweep the results need PIPE_REGS+1 steps to leave the array,
  // then stay available for one Z tile height while the next Y tile is pushed
  assign wait_last = wait_q == WAIT_W'(PIPE_REGS);
  assign wait_clr  = wait_en_q && !stall_i && wait_last;
  assign avail_clr = avail_en_q && !stall_i && (avail_q == z_height_last[DEPTH_W-1:0]);
  assign push_set  = (wait_en_q && !stall_i && (wait_q == WAIT_W'(PIPE_REGS - 1))) ||
                     start_comp_i;
  assign push_clr  = push_en_q && !stall_i && (push_q == y_height_last[DEPTH_W-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {y_cols_q, y_rows_q, wait_q, avail_q, push_q} <= '0;
      {wait_en_q, avail_en_q, push_en_q} <= '0;
      {z_width_q, z_height_q} <= '0;
    end else if (clear_i) begin
      {y_cols_q, y_rows_q, wait_q, avail_q, push_q} <= '0;
      {wait_en_q, avail_en_q, push_en_q} <= '0;
      {z_width_q, z_height_q} <= '0;
    end else begin
      if (z_empty_i) begin
        y_cols_q <= y_cols_wrap ? '0 : y_cols_q + 1'b1;
        if (y_cols_wrap) begin
          y_rows_q <= (y_rows_q == w_rows_last) ? '0 : y_rows_q + 1'b1;
        end
      end
      if (wait_clr) begin
        wait_en_q <= 1'b0;
      end else if (w_col_wrap_i) begin
        wait_en_q <= 1'b1;
      end
      if (wait_en_q && !stall_i) begin
        wait_q <= wait_last ? '0 : wait_q + 1'b1;
      end
      if (avail_clr) begin
        avail_en_q <= 1'b0;
      end else if (wait_clr) begin
        avail_en_q <= 1'b1;
      end
      if (avail_en_q && !stall_i) begin
        avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      end
      if (push_clr) begin
        push_en_q <= 1'b0;
      end else if (push_set) begin
        push_en_q <= 1'b1;
      end
      if (push_en_q && !stall_i) begin
        push_q <= push_clr ? '0 : push_q + 1'b1;
      end
      // The Z tile in flight keeps the size of the Y tile it started from
      if (z_empty_i || start_comp_i) begin
        z_width_q  <= y_width;
        z_height_q <= y_height;
      end
    end
  end

  assign y_width  = ((y_rows_q == w_rows_last) && (lo_w_height != '0)) ?
                    lo_w_height : DIM_W'(ARRAY_WIDTH);
  assign y_height = ((y_cols_q == w_cols_last) && (lo_w_width != '0)) ?
                    lo_w_width : DIM_W'(TOT_DEPTH);

  assign y_push_enable_o = push_en_q && !stall_i;
  assign z_fill_o        = avail_en_q && reg_enable_i;
  assign z_first_load_o  = (y_cols_q == '0) && (y_rows_q == '0);
  assign y_width_o       = y_width;
  assign y_height_o      = y_height;
  assign z_width_o       = z_width_q;
  assign z_height_o      = z_height_q;
  assign y_valid_o       = y_valid_i;
  assign z_ready_o       = z_ready_i;
  assign result_due_o    = wait_last;

endmodule

//--- redmule_engine_gate.sv
`timescale 1ns/100ps

module redmule_engine_gate (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    computing_i,
  input  logic                                    stall_i,
  input  logic                                    y_push_en_i,
  input  logic [redmule_cfg_pkg::DIM_W-1:0]       z_width_i,
  output logic                                    reg_enable_o,
  output logic                                    accumulate_o,
  output logic [redmule_cfg_pkg::ARRAY_WIDTH-1:0] row_clk_en_o
);
  import redmule_cfg_pkg::*;

  logic                   enable_d;
  logic                   pushing_q;
  logic [ARRAY_WIDTH-1:0] row_en_d;

  assign enable_d = computing_i && !stall_i;

  // Only the rows that hold a valid Z column are clocked
  always_comb begin
    for (int i = 0; i < ARRAY_WIDTH; i++) begin
      row_en_d[i] = enable_d && (DIM_W'(i) < z_width_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_enable_o <= 1'b0;
      row_clk_en_o <= '0;
      pushing_q    <= 1'b0;
    end else if (clear_i) begin
      reg_enable_o <= 1'b0;
      row_clk_en_o <= '0;
      pushing_q    <= 1'b0;
    end else begin
      reg_enable_o <= enable_d;
      row_clk_en_o <= row_en_d;
      pushing_q    <= y_push_en_i;
    end
  end

  // A fresh Y tile restarts the sum instead of accumulating onto it
  assign accumulate_o = !pushing_q;

endmodule

//--- redmule_scheduler.sv
`timescale 1ns/100ps

module redmule_scheduler (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    first_load_i,
  input  logic                                    y_required_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       x_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       w_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       leftovers_i,
  input  logic                                    x_valid_i,
  input  logic                                    w_valid_i,
  input  logic                                    y_valid_i,
  input  logic                                    z_ready_i,
  input  logic                                    x_full_i,
  input  logic                                    x_empty_i,
  input  logic                                    z_empty_i,
  input  logic                                    y_loaded_i,
  output logic                                    reg_enable_o,
  output logic [redmule_cfg_pkg::ARRAY_WIDTH-1:0] row_clk_en_o,
  output logic                                    accumulate_o,
  output logic                                    x_load_o,
  output logic                                    x_h_shift_o,
  output logic                                    x_pad_setup_o,
  output logic                                    x_rst_w_index_o,
  output logic                                    last_x_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       x_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       x_width_o,
  output logic                                    w_load_o,
  output logic                                    w_shift_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       w_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       w_width_o,
  output logic                                    w_loaded_o,
  output logic                                    y_push_enable_o,
  output logic                                    z_fill_o,
  output logic                                    z_first_load_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       y_width_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       y_height_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       z_width_o,
  output logic [redmule_cfg_pkg::DIM_W-1:0]       z_height_o,
  output logic                                    y_valid_o,
  output logic                                    z_ready_o
);

  logic load_w, shift_w, stall;
  logic start, start_comp, preload_exit, computing;
  logic x_check_en, w_done, w_col_wrap, result_due;

  // Ports named as on the top level connect by name
  redmule_sched_fsm i_sched_fsm (
    .x_check_en_i   (x_check_en),
    .result_due_i   (result_due),
    .w_done_i       (w_done),
    .load_w_o       (load_w),
    .shift_w_o      (shift_w),
    .stall_o        (stall),
    .start_o        (start),
    .start_comp_o   (start_comp),
    .preload_exit_o (preload_exit),
    .computing_o    (computing),
    .*
  );

  redmule_x_tile_ctrl i_x_tile_ctrl (
    .load_w_i       (load_w),
    .start_i        (start),
    .preload_exit_i (preload_exit),
    .x_check_en_o   (x_check_en),
    .*
  );

  redmule_w_tile_ctrl i_w_tile_ctrl (
    .load_w_i     (load_w),
    .shift_w_i    (shift_w),
    .w_done_o     (w_done),
    .w_col_wrap_o (w_col_wrap),
    .*
  );

  redmule_z_tile_ctrl i_z_tile_ctrl (
    .w_col_wrap_i (w_col_wrap),
    .stall_i      (stall),
    .start_comp_i (start_comp),
    .reg_enable_i (reg_enable_o),
    .result_due_o (result_due),
    .*
  );

  redmule_engine_gate i_engine_gate (
    .computing_i (computing),
    .stall_i     (stall),
    .y_push_en_i (y_push_enable_o),
    .z_width_i   (z_width_o),
    .*
  );

endmodule

//--- tb_sched_checker.sv
`timescale 1ns/100ps

module tb_sched_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    idle_i,
  input  logic [127:0]                            test_name_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       x_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       w_iters_i,
  input  logic [redmule_cfg_pkg::REG_W-1:0]       leftovers_i,
  input  logic                                    x_empty_i,
  input  logic                                    w_valid_i,
  input  logic                                    y_valid_i,
  input  logic                                    z_ready_i,
  input  logic                                    reg_enable_i,
  input  logic [redmule_cfg_pkg::ARRAY_WIDTH-1:0] row_clk_en_i,
  input  logic                                    last_x_i,
  input  logic [redmule_cfg_pkg::DIM_W-1:0]       x_height_i,
  input  logic [redmule_cfg_pkg::DIM_W-1:0]       x_width_i,
  input  logic [redmule_cfg_pkg::DIM_W-1:0]       z_width_i,
  input  logic [redmule_cfg_pkg::DIM_W-1:0]       z_height_i,
  input  logic                                    y_push_i,
  input  logic                                    accumulate_i,
  input  logic                                    y_valid_out_i,
  input  logic                                    z_ready_out_i,
  input  logic [11:0]                             ctrl_bits_i
);
  import redmule_cfg_pkg::*;

  int                     err_cnt = 0;
  int                     pulses = 0;
  bit                     done_seen = 0;
  bit                     prev_push = 0;
  logic [DIM_W-1:0]       prev_z_width = '0;

  task automatic report(input string what, input int exp_val, input int act_val);
    err_cnt++;
    $display("ERROR %0s %0s: expected %0d, actual %0d", test_name_i, what, exp_val, act_val);
  endtask

  always @(posedge clk_i) begin
    int                     x_cols;
    int                     total;
    int                     per_row;
    int                     exp_h;
    int                     exp_w;
    int                     lo_h;
    int                     lo_w;
    logic [ARRAY_WIDTH-1:0] exp_mask;
    if (rst_ni) begin
      x_cols  = int'(x_iters_i[15:0]);
      per_row = x_cols * int'(w_iters_i[15:0]);
      total   = per_row * int'(x_iters_i[31:16]);
      lo_h    = int'(leftovers_i[23:16]);
      lo_w    = int'(leftovers_i[31:24]);

      // Quiet window after reset or clear, before the test starts
      if (idle_i) begin
        pulses    = 0;
        done_seen = 0;
        if (ctrl_bits_i != '0) begin
          report("control outputs while idle", 0, int'(ctrl_bits_i));
        end
        if (z_width_i != '0 || z_height_i != '0) begin
          report("Z tile size while idle", 0, int'({z_width_i, z_height_i}));
        end
      end else begin
        if (!done_seen && !w_valid_i && ctrl_bits_i[0]) begin
          report("w_load without w_valid", 0, 1);
        end
        if (!done_seen && x_cols > 0) begin
          exp_h = TOT_DEPTH;
          if ((pulses % x_cols) == x_cols - 1 && lo_h != 0) begin
            exp_h = lo_h;
          end
          if (int'(x_height_i) != exp_h) begin
            report("x_height", exp_h, int'(x_height_i));
          end
        end
        // The X row index moves on after every column pass of every W sweep
        if (!done_seen && per_row > 0) begin
          exp_w = ARRAY_WIDTH;
          if (((pulses / per_row) == int'(x_iters_i[31:16]) - 1) && lo_w != 0) begin
            exp_w = lo_w;
          end
          if (int'(x_width_i) != exp_w) begin
            report("x_width", exp_w, int'(x_width_i));
          end
        end
        if (x_empty_i && !done_seen) begin
          pulses++;
          if (last_x_i != (pulses == total)) begin
            report("last_x on x_empty pulse", int'(pulses == total), int'(last_x_i));
          end
        end else if (last_x_i) begin
          report("last_x outside a final x_empty pulse", 0, 1);
        end
        if (last_x_i) begin
          done_seen = 1;
        end
      end

      // The row mask is built from the Z width seen one cycle earlier
      if (prev_z_width >= DIM_W'(ARRAY_WIDTH)) begin
        exp_mask = '1;
      end else begin
        exp_mask = (ARRAY_WIDTH'(1) << prev_z_width) - ARRAY_WIDTH'(1);
      end
      if (!reg_enable_i) begin
        exp_mask = '0;
      end
      if (row_clk_en_i != exp_mask || (reg_enable_i && row_clk_en_i == '0)) begin
        report("row_clk_en", int'(exp_mask), int'(row_clk_en_i));
      end
      prev_z_width = z_width_i;

      // Accumulation pauses in the cycle after a Y push
      if (accumulate_i != !prev_push) begin
        report("accumulate", int'(!prev_push), int'(accumulate_i));
      end
      prev_push = clear_i ? 1'b0 : y_push_i;

      if (y_valid_out_i != y_valid_i) begin
        report("y_valid pass-through", int'(y_valid_i), int'(y_valid_out_i));
      end
      if (z_ready_out_i != z_ready_i) begin
        report("z_ready pass-through", int'(z_ready_i), int'(z_ready_out_i));
      end
    end
  end

endmodule

//--- tb_redmule_scheduler.sv
`timescale 1ns/100ps

module tb_redmule_scheduler;
  import redmule_cfg_pkg::*;

  logic clk_i = 1'b0;
  logic rst_ni, clear_i, first_load_i, y_required_i;
  logic [REG_W-1:0] x_iters_i, w_iters_i, leftovers_i;
  logic x_valid_i, w_valid_i, y_valid_i, z_ready_i;
  logic x_full_i, x_empty_i, z_empty_i, y_loaded_i;

  logic reg_enable_o, accumulate_o, x_load_o, x_h_shift_o, x_pad_setup_o;
  logic x_rst_w_index_o, last_x_o, w_load_o, w_shift_o, w_loaded_o;
  logic y_push_enable_o, z_fill_o, z_first_load_o, y_valid_o, z_ready_o;
  logic [ARRAY_WIDTH-1:0] row_clk_en_o;
  logic [DIM_W-1:0] x_height_o, x_width_o, w_height_o, w_width_o;
  logic [DIM_W-1:0] y_width_o, y_height_o, z_width_o, z_height_o;

  logic [127:0]     names[8];
  logic [REG_W-1:0] xw[8], ww[8], lw[8];
  logic             yr[8];
  logic [127:0]     cur_name = '0;
  int  n_tests = 0, other_errs = 0, cycles = 0, limit = 0;
  int  load_cnt = 0, tiles_due = 0, x_gap = 0;
  bit  running = 0, idle = 1, z_drain = 0, zfill_prev = 0;

  always #2 clk_i = ~clk_i;

  redmule_scheduler i_dut (.*);

  tb_sched_checker i_chk (
    .clk_i, .rst_ni, .clear_i, .idle_i(idle), .test_name_i(cur_name), .x_iters_i, .w_iters_i,
    .leftovers_i, .x_empty_i, .w_valid_i, .y_valid_i, .z_ready_i, .reg_enable_i(reg_enable_o),
    .row_clk_en_i(row_clk_en_o), .last_x_i(last_x_o), .x_height_i(x_height_o),
    .x_width_i(x_width_o), .z_width_i(z_width_o), .z_height_i(z_height_o),
    .y_push_i(y_push_enable_o), .accumulate_i(accumulate_o),
    .y_valid_out_i(y_valid_o), .z_ready_out_i(z_ready_o),
    .ctrl_bits_i({x_rst_w_index_o, x_load_o, |row_clk_en_o, reg_enable_o, last_x_o,
                  z_fill_o, y_push_enable_o, x_h_shift_o, x_pad_setup_o, w_loaded_o,
                  w_shift_o, w_load_o})
  );

  task automatic closing_line();
    $display("Errors: check=%0d other=%0d", i_chk.err_cnt, other_errs);
  endtask

  // Every ARRAY_HEIGHT weight loads consume one X tile
  always @(posedge clk_i) begin
    cycles++;
    if (!running) begin
      load_cnt  = 0;
      tiles_due = 0;
    end else if (w_load_o) begin
      load_cnt++;
      if (load_cnt == ARRAY_HEIGHT) begin
        load_cnt = 0;
        tiles_due++;
      end
    end
    if (zfill_prev && !z_fill_o) begin
      z_drain = 1;
    end
    zfill_prev = z_fill_o;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the scheduler did not finish the tests within %0d cycles", limit);
      other_errs++;
      closing_line();
      $display("TEST FAILED");
      $finish;
    end
  end

  // Buffer and streamer models
  always @(negedge clk_i) begin
    x_empty_i <= 1'b0;
    z_empty_i <= z_drain;
    z_drain = 0;
    y_valid_i <= ($urandom % 2) != 0;
    z_ready_i <= ($urandom % 2) != 0;
    if (!running) begin
      x_full_i   <= 1'b0;
      y_loaded_i <= 1'b0;
      w_valid_i  <= 1'b1;
      x_gap = 2 + $urandom % 3;
    end else begin
      w_valid_i  <= ($urandom % 4) != 0;
      y_loaded_i <= 1'b1;
      if (x_gap > 0) begin
        x_gap--;
      end else if (tiles_due > 0 && ($urandom % 2) == 0) begin
        x_empty_i <= 1'b1;
        tiles_due--;
        x_gap = 1 + $urandom % 3;
      end
      x_full_i <= (x_gap == 0);
    end
  end

  initial begin
    int    fd, rc;
    string line;
    void'($urandom(74));
    rst_ni = 1'b0;
    {clear_i, first_load_i, y_required_i} = '0;
    {x_iters_i, w_iters_i, leftovers_i} = '0;
    x_valid_i = 1'b1;
    {y_valid_i, z_ready_i} <= 2'b11;
    {w_valid_i, x_full_i, x_empty_i, z_empty_i, y_loaded_i} <= 5'b10000;
    fd = $fopen("sched_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file sched_testdata.txt");
      other_errs++;
    end else begin
      while (!$feof(fd) && n_tests < 8) begin
        line = "";
        rc = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%s %h %h %h %h", names[n_tests], xw[n_tests],
                       ww[n_tests], lw[n_tests], yr[n_tests]);
          if (rc == 5) begin
            limit += int'(xw[n_tests][15:0]) * int'(ww[n_tests][15:0]) *
                     int'(xw[n_tests][31:16]) * (PIPE_REGS + 2) * ARRAY_HEIGHT;
            n_tests++;
          end
        end
      end
      $fclose(fd);
      if (n_tests == 0) begin
        $display("The test data file holds no usable test line");
        other_errs++;
      end
    end
    limit = 2 * limit + 200;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      @(negedge clk_i);
      idle = 0;
      cur_name = names[t];
      x_iters_i = xw[t];
      w_iters_i = ww[t];
      leftovers_i = lw[t];
      y_required_i = yr[t];
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
      idle = 1;
      repeat (3) @(negedge clk_i);
      idle = 0;
      first_load_i = 1'b1;
      running <= 1'b1;
      @(negedge clk_i);
      first_load_i = 1'b0;
      @(posedge clk_i);
      while (!last_x_o) @(posedge clk_i);
      @(negedge clk_i);
      running <= 1'b0;
      repeat (4) @(negedge clk_i);
    end
    closing_line();
    if (i_chk.err_cnt == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sched_testdata.txt
# name x_iters(rows:cols) w_iters(rows:cols) leftovers(xw:xh:wh:ww) y_required
# Iteration words hold rows in bits 31:16 and columns in bits 15:0
single_tile 00010001 00060001 00000000 0
x_height_edge 00010002 000a0002 00050000 1
mixed_edges 00020003 000e0001 07090302 1
x_width_edge 00020001 00060003 0a000000 0

//--- project.f
redmule_cfg_pkg.sv
redmule_reg_pkg.sv
redmule_sched_fsm.sv
redmule_x_tile_ctrl.sv
redmule_w_tile_ctrl.sv
redmule_z_tile_ctrl.sv
redmule_engine_gate.sv
redmule_scheduler.sv
tb_sched_checker.sv
tb_redmule_scheduler.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_redmule_scheduler -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi
